//--- design/cpu_types_pkg.sv
package cpu_types_pkg;

    localparam int DATA_WIDTH        = 32;                      // Data word width
    localparam int INST_ADDR_WIDTH   = 32;                      // Program counter width
    localparam int REG_ADDR_WIDTH    = 5;                       // Register number width
    localparam int MEM_WORDS         = 256;                     // Data RAM depth in words
    localparam int MEM_INDEX_WIDTH   = $clog2(MEM_WORDS);       // Word index bits
    localparam int BYTE_OFFSET_WIDTH = 2;                       // Byte offset inside a word
    localparam int BYTES_PER_WORD    = DATA_WIDTH / 8;          // Byte lanes per word

    typedef logic [DATA_WIDTH-1:0]        data_t;               // Data word
    typedef logic [INST_ADDR_WIDTH-1:0]   inst_addr_t;          // Program counter
    typedef logic [REG_ADDR_WIDTH-1:0]    reg_addr_t;           // Register number
    typedef logic [MEM_INDEX_WIDTH-1:0]   mem_index_t;          // RAM word index
    typedef logic [BYTE_OFFSET_WIDTH-1:0] byte_offset_t;        // Byte lane of an address
    typedef logic [BYTES_PER_WORD-1:0]    byte_enable_t;        // One bit per byte lane
    typedef logic [1:0]                   data_access_t;        // Memory access size
    typedef logic [1:0]                   wb_sel_t;             // Writeback value source

    // Access size encodings, value 3 is unused
    localparam data_access_t ACCESS_BYTE = 2'd0;                // 8 bit access
    localparam data_access_t ACCESS_HALF = 2'd1;                // 16 bit access
    localparam data_access_t ACCESS_WORD = 2'd2;                // 32 bit access

    // Writeback source encodings, value 3 is unused
    localparam wb_sel_t WB_SEL_RESULT  = 2'd0;                  // ALU result
    localparam wb_sel_t WB_SEL_MEMORY  = 2'd1;                  // Loaded data
    localparam wb_sel_t WB_SEL_PC_NEXT = 2'd2;                  // Return address, pc + 4

    localparam inst_addr_t PC_STEP = 4;                         // Size of one instruction

endpackage

//--- design/pipeline_pkg.sv
package pipeline_pkg;

    import cpu_types_pkg::*;

    // Contents of the EX/MEM register
    typedef struct packed {
        logic         is_valid;                                 // Item holds a real instruction
        inst_addr_t   pc;                                       // Instruction address
        data_t        result;                                   // ALU result, also memory address
        data_t        data_b;                                   // Store data
        logic         mem_wr_enable;                            // Store request
        logic         mem_rd_enable;                            // Load request
        data_access_t mem_access;                               // Access size
        logic         mem_unsigned;                             // Zero extend on load
        reg_addr_t    reg_wr_addr;                              // Destination register
        logic         reg_wr_enable;                            // Register write request
        wb_sel_t      reg_wr_data_sel;                          // Writeback source
    } ex_mem_t;

    // Contents of the MEM/WB register, the loaded word travels beside it
    typedef struct packed {
        logic         is_valid;                                 // Item holds a real instruction
        inst_addr_t   pc;                                       // For pc + 4 writeback
        data_t        result;                                   // ALU result
        data_access_t mem_access;                               // Load size for extension
        logic         mem_unsigned;                             // Zero extend on load
        byte_offset_t byte_offset;                              // Lane of the loaded value
        reg_addr_t    reg_wr_addr;                              // Destination register
        logic         reg_wr_enable;                            // Register write request
        wb_sel_t      reg_wr_data_sel;                          // Writeback source
    } mem_wb_t;

    // Register file write request
    typedef struct packed {
        logic         valid;                                    // Valid item in writeback
        logic         reg_wr_enable;                            // Write gated with valid
        reg_addr_t    reg_wr_addr;                              // Destination register
        data_t        reg_wr_data;                              // Value to write
    } wb_t;

endpackage

//--- design/ex_mem_register.sv
`timescale 1ns/1ns

module ex_mem_register
    import cpu_types_pkg::*, pipeline_pkg::*;
(
    input  logic    i_clock,                                    // Clock
    input  logic    i_arst_n,                                   // Async reset, active low
    input  logic    i_stall,                                    // Hold contents, wins over flush
    input  logic    i_flush,                                    // Drop the entering item
    input  ex_mem_t i_ex,                                       // From execute
    output ex_mem_t o_ex                                        // To memory stage
);

    logic    valid_q;                                           // Valid bit, the only reset flop
    ex_mem_t data_q;                                            // Payload, no reset

    // True when the address suits the access size
    function automatic logic is_aligned(input data_access_t access, input data_t addr);
        logic ok;
        case (access)
            ACCESS_BYTE: ok = 1'b1;
            ACCESS_HALF: ok = (addr[0] == 1'b0);
            default:     ok = (addr[BYTE_OFFSET_WIDTH-1:0] == '0);
        endcase
        return ok;
    endfunction

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;                                    // Empty after reset
        else if (!i_stall)
            valid_q <= i_flush ? 1'b0 : i_ex.is_valid;          // Flush turns item into bubble
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_stall && !i_flush)
            data_q <= i_ex;                                     // Normal capture
    end

    always_comb
    begin
        o_ex          = data_q;
        o_ex.is_valid = valid_q;                                // Valid comes from reset flop
    end

    // A captured memory access must be aligned when it reaches the RAM
    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (!i_stall && !i_flush && i_ex.is_valid && (i_ex.mem_wr_enable || i_ex.mem_rd_enable))
        |=> is_aligned(o_ex.mem_access, o_ex.result))
    else
        $error("misaligned memory access at pc %h", o_ex.pc);

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ns

module data_ram
    import cpu_types_pkg::*, pipeline_pkg::*;
(
    input  logic    i_clock,                                    // Clock
    input  logic    i_stall,                                    // Freeze write and read
    input  ex_mem_t i_ex,                                       // Access from EX/MEM
    output data_t   o_rd_word,                                  // Registered read word
    output logic    o_store_active                              // Valid store this cycle
);

    data_t        mem [MEM_WORDS];                              // Word storage
    data_t        rd_q;                                         // Read register
    mem_index_t   index;                                        // Addressed word
    byte_offset_t offset;                                       // Addressed lane
    data_t        wr_data;                                      // Store data moved to its lanes
    byte_enable_t wr_lanes;                                     // Lanes touched by the store
    logic         do_store;                                     // Write this edge
    logic         do_load;                                      // Read this edge

    assign index  = i_ex.result[BYTE_OFFSET_WIDTH +: MEM_INDEX_WIDTH];  // Word index above offset
    assign offset = i_ex.result[BYTE_OFFSET_WIDTH-1:0];

    assign do_store = i_ex.is_valid && i_ex.mem_wr_enable && !i_stall;
    assign do_load  = i_ex.is_valid && i_ex.mem_rd_enable && !i_stall;

    // Place the low bytes of data_b on the lanes picked by the offset
    always_comb
    begin
        wr_data = i_ex.data_b << {offset, 3'b000};              // Offset in bits
        case (i_ex.mem_access)
            ACCESS_BYTE: wr_lanes = byte_enable_t'(4'b0001) << offset;
            ACCESS_HALF: wr_lanes = byte_enable_t'(4'b0011) << offset;
            default:     wr_lanes = '1;                         // Whole word
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (do_store)
        begin
            for (int lane = 0; lane < BYTES_PER_WORD; lane++)
            begin
                if (wr_lanes[lane])
                    mem[index][lane*8 +: 8] <= wr_data[lane*8 +: 8];  // Only enabled lanes
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (do_load)
            rd_q <= mem[index];                                 // Whole word, aligned later
    end

    assign o_rd_word      = rd_q;
    assign o_store_active = do_store;                           // Visible store strobe

    // The EX/MEM item never asks for both directions at once
    assert property (@(posedge i_clock)
        i_ex.is_valid |-> !(i_ex.mem_wr_enable && i_ex.mem_rd_enable))
    else
        $error("store and load enabled together at pc %h", i_ex.pc);

endmodule

//--- design/mem_wb_register.sv
`timescale 1ns/1ns

module mem_wb_register
    import cpu_types_pkg::*, pipeline_pkg::*;
(
    input  logic    i_clock,                                    // Clock
    input  logic    i_arst_n,                                   // Async reset, active low
    input  logic    i_stall,                                    // Hold contents
    input  ex_mem_t i_ex,                                       // From EX/MEM
    output mem_wb_t o_mem                                       // To writeback select
);

    logic    valid_q;                                           // Reset flop
    mem_wb_t data_q;                                            // Payload, is_valid field unused

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;
        else if (!i_stall)
            valid_q <= i_ex.is_valid;                           // Bubbles pass through
    end

    // Same edge as the RAM read so the fields line up with rd_word
    always_ff @(posedge i_clock)
    begin
        if (!i_stall)
        begin
            data_q.pc              <= i_ex.pc;
            data_q.result          <= i_ex.result;
            data_q.mem_access      <= i_ex.mem_access;
            data_q.mem_unsigned    <= i_ex.mem_unsigned;
            data_q.byte_offset     <= i_ex.result[BYTE_OFFSET_WIDTH-1:0];  // Lane for the load
            data_q.reg_wr_addr     <= i_ex.reg_wr_addr;
            data_q.reg_wr_enable   <= i_ex.reg_wr_enable;
            data_q.reg_wr_data_sel <= i_ex.reg_wr_data_sel;
        end
    end

    always_comb
    begin
        o_mem.is_valid        = valid_q;
        o_mem.pc              = data_q.pc;
        o_mem.result          = data_q.result;
        o_mem.mem_access      = data_q.mem_access;
        o_mem.mem_unsigned    = data_q.mem_unsigned;
        o_mem.byte_offset     = data_q.byte_offset;
        o_mem.reg_wr_addr     = data_q.reg_wr_addr;
        o_mem.reg_wr_enable   = data_q.reg_wr_enable;
        o_mem.reg_wr_data_sel = data_q.reg_wr_data_sel;
    end

endmodule

//--- design/writeback_select.sv
`timescale 1ns/1ns

module writeback_select
    import cpu_types_pkg::*, pipeline_pkg::*;
(
    input  mem_wb_t i_mem,                                      // MEM/WB contents
    input  data_t   i_rd_word,                                  // Registered RAM word
    output wb_t     o_wb                                        // Register file write
);

    data_t shifted;                                             // Loaded value in low lanes
    data_t load_value;                                          // Extended load
    data_t wr_data;                                             // Selected writeback value
    logic  fill_half;                                           // Sign fill for half loads
    logic  fill_byte;                                           // Sign fill for byte loads

    assign shifted   = i_rd_word >> {i_mem.byte_offset, 3'b000};
    assign fill_byte = !i_mem.mem_unsigned && shifted[7];       // Zero when unsigned
    assign fill_half = !i_mem.mem_unsigned && shifted[15];

    always_comb
    begin
        case (i_mem.mem_access)
            ACCESS_BYTE: load_value = {{24{fill_byte}}, shifted[7:0]};
            ACCESS_HALF: load_value = {{16{fill_half}}, shifted[15:0]};
            default:     load_value = shifted;                  // Word needs no extension
        endcase
    end

    always_comb
    begin
        case (i_mem.reg_wr_data_sel)
            WB_SEL_MEMORY:  wr_data = load_value;
            WB_SEL_PC_NEXT: wr_data = data_t'(i_mem.pc + PC_STEP);  // Link address
            default:        wr_data = i_mem.result;
        endcase
    end

    always_comb
    begin
        o_wb.valid         = i_mem.is_valid;
        o_wb.reg_wr_enable = i_mem.is_valid && i_mem.reg_wr_enable;  // Bubbles never write
        o_wb.reg_wr_addr   = i_mem.reg_wr_addr;
        o_wb.reg_wr_data   = wr_data;
    end

    // No clock here, so the source check runs on every change of the input
    always_comb
    begin
        if (i_mem.is_valid)
        begin
            assert (i_mem.reg_wr_data_sel inside {WB_SEL_RESULT, WB_SEL_MEMORY, WB_SEL_PC_NEXT})
            else
                $error("unused writeback source %0d at pc %h",
                       i_mem.reg_wr_data_sel, i_mem.pc);
        end
    end

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
    import cpu_types_pkg::*, pipeline_pkg::*;
(
    input  logic    i_clock,                                    // Clock
    input  logic    i_arst_n,                                   // Async reset, active low
    input  logic    i_stall,                                    // Freeze the whole stage
    input  logic    i_flush,                                    // Drop the entering item
    input  ex_mem_t i_ex,                                       // Item from execute
    output wb_t     o_wb,                                       // Register write, two cycles on
    output logic    o_mem_busy_store                            // RAM is writing
);

    ex_mem_t ex_q;                                              // EX/MEM contents
    mem_wb_t mem_q;                                             // MEM/WB contents
    data_t   rd_word;                                           // RAM read register

    ex_mem_register u_ex_mem_register (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_flush  (i_flush),
        .i_ex     (i_ex),
        .o_ex     (ex_q)
    );

    // RAM and MEM/WB register both load from ex_q on the same edge
    data_ram u_data_ram (
        .i_clock        (i_clock),
        .i_stall        (i_stall),
        .i_ex           (ex_q),
        .o_rd_word      (rd_word),
        .o_store_active (o_mem_busy_store)
    );

    mem_wb_register u_mem_wb_register (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_ex     (ex_q),
        .o_mem    (mem_q)
    );

    writeback_select u_writeback_select (
        .i_mem     (mem_q),
        .i_rd_word (rd_word),
        .o_wb      (o_wb)
    );

endmodule

//--- sim/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb
    import cpu_types_pkg::*, pipeline_pkg::*;
();

    localparam int    CLOCK_PERIOD    = 40;                     // ns
    localparam int    RESET_CYCLES    = 8;
    localparam int    WATCHDOG_MARGIN = 20;                     // Spare cycles past the last line
    localparam int    MIN_LINES       = 20;                     // Fewer means a cut file
    localparam int    NUM_COLUMNS     = 18;                     // 13 inputs and 5 expected
    localparam string DATA_FILE       = "sim/mem_stage_testdata.txt";
    localparam wb_t   IDLE_WB         = '0;                     // Empty writeback slot

    logic    i_clock = 1'b0;
    logic    i_arst_n;
    logic    i_stall;
    logic    i_flush;
    ex_mem_t i_ex;
    wb_t     o_wb;
    logic    o_mem_busy_store;

    logic    stim_stall [$];                                    // One entry per data line
    logic    stim_flush [$];
    ex_mem_t stim_ex    [$];
    wb_t     exp_wb     [$];                                    // Outputs after the line's edge
    logic    exp_busy   [$];
    logic    data_loaded = 1'b0;                                // Starts the watchdog

    mem_stage u_mem_stage (
        .i_clock          (i_clock),
        .i_arst_n         (i_arst_n),
        .i_stall          (i_stall),
        .i_flush          (i_flush),
        .i_ex             (i_ex),
        .o_wb             (o_wb),
        .o_mem_busy_store (o_mem_busy_store)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    // Address and data only matter when the register file writes
    task automatic check_wb(input wb_t actual, input wb_t expected, input string where);
        logic match;
        match = (actual.valid === expected.valid)
             && (actual.reg_wr_enable === expected.reg_wr_enable);
        if (expected.reg_wr_enable)
            match = match && (actual.reg_wr_addr === expected.reg_wr_addr)
                          && (actual.reg_wr_data === expected.reg_wr_data);
        if (!match)
            abort_run($sformatf("error: o_wb at %s expected %h actual %h",
                                where, expected, actual));
    endtask

    task automatic check_busy(input logic actual, input logic expected, input string where);
        if (actual !== expected)
            abort_run($sformatf("error: o_mem_busy_store at %s expected %h actual %h",
                                where, expected, actual));
    endtask

    // Comment and blank lines yield no hex fields and are skipped
    task automatic load_testdata();
        int          fd;
        int          fields;
        string       text;
        logic [31:0] col [NUM_COLUMNS];
        ex_mem_t     item;
        wb_t         wb;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
            abort_run({"The stimulus file could not be opened: ", DATA_FILE});
        while ($fgets(text, fd) != 0)
        begin
            fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                             col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                             col[15], col[16], col[17]);
            if (fields <= 0)
                continue;
            if (fields != NUM_COLUMNS)
                abort_run($sformatf("A stimulus line has %0d columns where %0d are needed",
                                    fields, NUM_COLUMNS));
            item.is_valid        = col[2][0];
            item.pc              = col[3];
            item.result          = col[4];                  // Also the memory address
            item.data_b          = col[5];
            item.mem_wr_enable   = col[6][0];
            item.mem_rd_enable   = col[7][0];
            item.mem_access      = col[8][1:0];
            item.mem_unsigned    = col[9][0];
            item.reg_wr_addr     = col[10][REG_ADDR_WIDTH-1:0];
            item.reg_wr_enable   = col[11][0];
            item.reg_wr_data_sel = col[12][1:0];
            wb.valid             = col[13][0];
            wb.reg_wr_enable     = col[14][0];
            wb.reg_wr_addr       = col[15][REG_ADDR_WIDTH-1:0];
            wb.reg_wr_data       = col[16];
            stim_stall.push_back(col[0][0]);
            stim_flush.push_back(col[1][0]);
            stim_ex.push_back(item);
            exp_wb.push_back(wb);
            exp_busy.push_back(col[17][0]);
        end
        $fclose(fd);
        if (stim_ex.size() < MIN_LINES)
            abort_run($sformatf("The stimulus file is too short, only %0d cycles were read",
                                stim_ex.size()));
    endtask

    initial
    begin
        forever
            #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial
    begin
        i_arst_n <= 1'b0;                                       // Reset from time zero
        i_stall  <= 1'b0;
        i_flush  <= 1'b0;
        i_ex     <= '0;
        load_testdata();
        data_loaded = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(negedge i_clock);                                 // Outputs settled mid cycle
            check_wb(o_wb, IDLE_WB, $sformatf("reset cycle %0d", c));
            check_busy(o_mem_busy_store, 1'b0, $sformatf("reset cycle %0d", c));
        end
        @(posedge i_clock);
        i_arst_n <= 1'b1;
        for (int k = 0; k < stim_ex.size(); k++)
        begin
            @(posedge i_clock);
            i_stall <= stim_stall[k];
            i_flush <= stim_flush[k];
            i_ex    <= stim_ex[k];
            @(negedge i_clock);
            check_wb(o_wb, exp_wb[k], $sformatf("line %0d", k));
            check_busy(o_mem_busy_store, exp_busy[k], $sformatf("line %0d", k));
        end
        $display("Finished with no errors");
        $finish;
    end

    // Run length scales with the number of data lines
    initial
    begin
        int limit_ns;
        wait (data_loaded);
        limit_ns = (stim_ex.size() + WATCHDOG_MARGIN) * CLOCK_PERIOD;
        #(limit_ns);
        abort_run($sformatf("Timeout, the run did not finish within %0d ns", limit_ns));
    end

endmodule

//--- sim/mem_stage_testdata.txt
// In: stall flush valid pc result data_b mem_wr mem_rd access unsigned reg_addr reg_we wb_sel
// Expected after the edge: wb_valid wb_reg_we wb_reg_addr wb_reg_data busy_store (all hex)
0 0 0 00000000 00000000 00000000 0 0 0 0 00 0 0  0 0 00 00000000 0
0 0 0 00000000 00000000 00000000 0 0 0 0 00 0 0  0 0 00 00000000 0
0 0 1 00000100 00000040 12345678 1 0 2 0 00 0 0  0 0 00 00000000 0
0 0 1 00000104 00000040 00000000 0 1 2 0 05 1 1  0 0 00 00000000 1
0 0 1 00000108 00000041 000000f0 1 0 0 0 00 0 0  1 0 00 00000000 0
0 0 1 0000010c 00000042 00008001 1 0 1 0 00 0 0  1 1 05 12345678 1
0 0 1 00000110 00000041 00000000 0 1 0 0 06 1 1  1 0 00 00000000 1
0 0 1 00000114 00000041 00000000 0 1 0 1 07 1 1  1 0 00 00000000 0
0 0 1 00000118 00000042 00000000 0 1 1 0 08 1 1  1 1 06 fffffff0 0
0 0 1 0000011c 00000042 00000000 0 1 1 1 09 1 1  1 1 07 000000f0 0
0 0 1 00000120 00000040 00000000 0 1 2 0 0a 1 1  1 1 08 ffff8001 0
0 0 1 00000124 00000abc 00000000 0 0 2 0 0b 1 0  1 1 09 00008001 0
0 0 1 00000128 00000200 00000000 0 0 2 0 01 1 2  1 1 0a 8001f078 0
0 0 1 0000012c 00000044 deadbeef 1 0 2 0 00 0 0  1 1 0b 00000abc 0
1 1 1 00000130 00000044 00000000 0 1 2 0 0c 1 1  1 1 01 0000012c 0
0 0 1 00000130 00000044 00000000 0 1 2 0 0c 1 1  1 1 01 0000012c 1
0 0 1 00000134 00000077 00000000 0 0 2 0 0d 1 0  1 0 00 00000000 0
0 1 1 00000138 00000044 11111111 1 0 2 0 00 0 0  1 1 0c deadbeef 0
0 0 1 0000013c 00000044 00000000 0 1 2 0 0e 1 1  1 1 0d 00000077 0
0 0 0 00000000 00000000 00000000 0 0 0 0 00 0 0  0 0 00 00000000 0
0 0 0 00000000 00000000 00000000 0 0 0 0 00 0 0  1 1 0e deadbeef 0
0 0 0 00000000 00000000 00000000 0 0 0 0 00 0 0  0 0 00 00000000 0

//--- mem_stage.f
design/cpu_types_pkg.sv
design/pipeline_pkg.sv
design/ex_mem_register.sv
design/data_ram.sv
design/mem_wb_register.sv
design/writeback_select.sv
design/mem_stage.sv
sim/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module mem_stage_tb -f mem_stage.f -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim | tee /dev/stderr | grep -q "^Finished with no errors$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
